// ==== tb.f ====
src/fir_dsp_pkg.sv
src/fir_dsp_pipe_ctrl.sv
src/fir_dsp_coef_bank.sv
src/fir_dsp_preadd.sv
src/fir_dsp_mac.sv
src/fir_dsp_core.sv
verif/fir_dsp_tb.sv

// ==== verif/fir_dsp_tb.sv ====
`timescale 1ns/1ps

module fir_dsp_tb;

    localparam int PREADD_REG = 1;
    localparam int MULT_REG   = 1;
    localparam int LATENCY    = 2 + PREADD_REG + MULT_REG;
    localparam fir_dsp_pkg::acc_t RND_VAL = 48'h400;
    localparam int TBL_N   = 16;
    localparam int TIMEOUT = 20 * TBL_N + 100;
    localparam int D_MAX   = 2**25 - 1;
    localparam int D_MIN   = -(2**25);
    localparam int C_MAX   = 2**17 - 1;
    localparam int C_MIN   = -(2**17);

    logic               clk_i, rst_i, in_valid_i, out_ready_i, coef_load_i, coef_update_i;
    logic               in_ready_o, out_valid_o;
    fir_dsp_pkg::data_t a_i, d_i;
    fir_dsp_pkg::coef_t coef_i, coef_cascade_o;
    fir_dsp_pkg::acc_t  c_i, pcin_i, p_o, pcout_o;

    // Stimulus table where act bit 0 loads the coefficient and bit 1 updates it
    logic [1:0]         tbl_act  [TBL_N];
    fir_dsp_pkg::coef_t tbl_coef [TBL_N];
    fir_dsp_pkg::data_t tbl_a    [TBL_N];
    fir_dsp_pkg::data_t tbl_d    [TBL_N];
    fir_dsp_pkg::acc_t  tbl_c    [TBL_N];
    fir_dsp_pkg::acc_t  tbl_pcin [TBL_N];
    fir_dsp_pkg::acc_t  tbl_exp  [TBL_N];
    fir_dsp_pkg::coef_t model_shadow, model_work;

    fir_dsp_pkg::acc_t exp_q[$];
    int                cyc_q[$];
    int                cycle_cnt, acc_cnt, res_cnt;
    logic              hold_pending, rand_ready;
    fir_dsp_pkg::acc_t held_p;

    fir_dsp_core #(
        .RND_VAL (RND_VAL)
    ) u_dut (
        .clk_i (clk_i), .rst_i (rst_i), .in_valid_i (in_valid_i), .out_ready_i (out_ready_i),
        .coef_load_i (coef_load_i), .coef_update_i (coef_update_i),
        .a_i (a_i), .d_i (d_i), .coef_i (coef_i), .c_i (c_i), .pcin_i (pcin_i),
        .in_ready_o (in_ready_o), .out_valid_o (out_valid_o), .p_o (p_o), .pcout_o (pcout_o),
        .coef_cascade_o (coef_cascade_o)
    );

    always #2 clk_i = ~clk_i;

    ////////////////////
    // Helpers
    ////////////////////

    task automatic stop_failed();
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            stop_failed();
        end
    endtask

    // (d + a) * coef + c + pcin + rounding wrapped to 48 bits
    function automatic fir_dsp_pkg::acc_t expected_p(input fir_dsp_pkg::data_t a,
            input fir_dsp_pkg::data_t d, input fir_dsp_pkg::acc_t c,
            input fir_dsp_pkg::acc_t pcin, input fir_dsp_pkg::coef_t coef);
        longint sum;
        sum = (longint'(d) + longint'(a)) * longint'(coef);
        sum = sum + longint'(c) + longint'(pcin) + longint'(RND_VAL);
        return sum[47:0];
    endfunction

    task automatic set_row(input int idx, input logic [1:0] act, input int coef,
                           input int a, input int d,
                           input fir_dsp_pkg::acc_t c, input fir_dsp_pkg::acc_t pcin);
        tbl_act[idx]  = act;
        tbl_coef[idx] = fir_dsp_pkg::coef_t'(coef);
        tbl_a[idx]    = fir_dsp_pkg::data_t'(a);
        tbl_d[idx]    = fir_dsp_pkg::data_t'(d);
        tbl_c[idx]    = c;
        tbl_pcin[idx] = pcin;
        // Track the double buffer so each sample gets the tap in use at acceptance
        if (act[0]) model_shadow = tbl_coef[idx];
        if (act[1]) model_work = model_shadow;
        tbl_exp[idx] = expected_p(tbl_a[idx], tbl_d[idx], c, pcin, model_work);
    endtask

    // Runs the row's coefficient action, then holds the sample until accepted
    task automatic send_row(input int idx);
        logic taken;
        if (tbl_act[idx][0]) begin
            coef_i      = tbl_coef[idx];
            coef_load_i = 1'b1;
            @(negedge clk_i);
            coef_load_i = 1'b0;
            check_value(coef_cascade_o, tbl_coef[idx], "coef_cascade_o after load");
        end
        if (tbl_act[idx][1]) begin
            coef_update_i = 1'b1;
            @(negedge clk_i);
            coef_update_i = 1'b0;
        end
        a_i        = tbl_a[idx];
        d_i        = tbl_d[idx];
        c_i        = tbl_c[idx];
        pcin_i     = tbl_pcin[idx];
        in_valid_i = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            @(posedge clk_i);
            taken = in_ready_o;
        end
        @(negedge clk_i);
        in_valid_i = 1'b0;
    endtask

    ////////////////////
    // Monitor and timeout
    ////////////////////

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout after %0d cycles, results stopped coming out", cycle_cnt);
            stop_failed();
        end else if (!rst_i) begin
            if (hold_pending) begin
                check_value(out_valid_o, 1'b1, "held result was dropped");
                check_value(p_o, held_p, "p_o changed while held");
            end
            hold_pending = out_valid_o && !out_ready_i;
            held_p       = p_o;
            if (hold_pending) check_value(in_ready_o, 1'b0, "in_ready_o high during stall");
            if (in_valid_i && in_ready_o) begin
                exp_q.push_back(tbl_exp[acc_cnt % TBL_N]);
                cyc_q.push_back(rand_ready ? -1 : cycle_cnt);
                acc_cnt++;
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("A result came out at %0t ns with no sample in flight", $time);
                    stop_failed();
                end else begin
                    check_value(p_o, exp_q.pop_front(), "p_o value");
                    check_value(pcout_o, p_o, "pcout_o differs from p_o");
                    // Latency only holds while the output side never stalls
                    if (cyc_q[0] >= 0) check_value(cycle_cnt - cyc_q[0], LATENCY, "latency");
                    void'(cyc_q.pop_front());
                    res_cnt++;
                end
            end
        end
    end

    // Output side ready, random only in the back-pressure pass
    initial begin
        void'($urandom(32'h2230_94f4));
        forever begin
            @(negedge clk_i);
            if (rand_ready) out_ready_i = ($urandom % 3) != 0;
            else out_ready_i = 1'b1;
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        in_valid_i = 1'b0;
        out_ready_i = 1'b1;
        coef_load_i = 1'b0;
        coef_update_i = 1'b0;
        coef_i = '0;
        a_i = '0;
        d_i = '0;
        c_i = '0;
        pcin_i = '0;
        cycle_cnt = 0;
        acc_cnt = 0;
        res_cnt = 0;
        hold_pending = 1'b0;
        rand_ready = 1'b0;
        held_p = '0;
        model_shadow = '0;
        model_work = '0;

        set_row(0,  2'b11, 1234,  5,      7,       48'h0,              48'h0);
        set_row(1,  2'b00, 0,     -3,     10,      48'h10,             48'h20);
        set_row(2,  2'b00, 0,     D_MAX,  D_MAX,   48'h0,              48'h0);
        set_row(3,  2'b00, 0,     D_MIN,  D_MIN,   48'h7FFF_FFFF_FFFF, 48'h1);
        set_row(4,  2'b11, C_MIN, D_MAX,  D_MAX,   48'h0,              48'h0);
        set_row(5,  2'b00, 0,     D_MIN,  D_MIN,   48'h0,              48'hFFFF_FFFF_FFFF);
        // Load only so these two still see the old working tap
        set_row(6,  2'b01, 777,   100,    -50,     48'hFFFF_FFFF_FFFF, 48'h1);
        set_row(7,  2'b00, 0,     1,      1,       48'h0,              48'h0);
        set_row(8,  2'b10, 0,     1000,   2000,    48'h0,              48'h0);
        set_row(9,  2'b00, 0,     -1000,  -2000,   48'h8000_0000_0000, 48'h8000_0000_0000);
        set_row(10, 2'b11, C_MAX, D_MIN,  D_MAX,   48'h5,              48'h0);
        set_row(11, 2'b00, 0,     123456, -654321, 48'h0123_4567_89AB, 48'hFEDC_BA98_7654);
        set_row(12, 2'b01, -5,    2,      3,       48'h0,              48'h0);
        set_row(13, 2'b10, 0,     2,      3,       48'h0,              48'h0);
        set_row(14, 2'b00, 0,     0,      0,       48'h0,              48'h0);
        set_row(15, 2'b00, 0,     -1,     0,       48'hFFFF_FFFF_FC00, 48'h0);

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        check_value(out_valid_o, 1'b0, "out_valid_o after reset");
        check_value(in_ready_o, 1'b1, "in_ready_o after reset");
        check_value(coef_cascade_o, 0, "coef_cascade_o after reset");

        // First pass with the output always ready
        for (int i = 0; i < TBL_N; i++) send_row(i);
        while (exp_q.size() != 0) @(negedge clk_i);

        // Second pass under random back-pressure
        rand_ready <= 1'b1;
        for (int i = 0; i < TBL_N; i++) send_row(i);
        while (exp_q.size() != 0) @(negedge clk_i);
        rand_ready <= 1'b0;
        repeat (LATENCY + 2) @(negedge clk_i);
        check_value(out_valid_o, 1'b0, "out_valid_o after the last result");
        check_value(res_cnt, 2 * TBL_N, "number of results");

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== src/fir_dsp_core.sv ====
`timescale 1ns/1ps

module fir_dsp_core #(
    parameter bit                USE_D      = 1'b1,
    parameter bit                SUBTRACT_A = 1'b0,
    parameter bit                SUBTRACT_C = 1'b0,
    parameter bit                USE_C      = 1'b1,
    parameter bit                ADD_PCIN   = 1'b1,
    parameter fir_dsp_pkg::acc_t RND_VAL    = '0,
    parameter int                PREADD_REG = 1,
    parameter int                MULT_REG   = 1
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               in_valid_i,
    input  logic               out_ready_i,
    input  logic               coef_load_i,
    input  logic               coef_update_i,
    input  fir_dsp_pkg::data_t a_i,
    input  fir_dsp_pkg::data_t d_i,
    input  fir_dsp_pkg::coef_t coef_i,
    input  fir_dsp_pkg::acc_t  c_i,
    input  fir_dsp_pkg::acc_t  pcin_i,
    output logic               in_ready_o,
    output logic               out_valid_o,
    output fir_dsp_pkg::acc_t  p_o,
    output fir_dsp_pkg::acc_t  pcout_o,
    output fir_dsp_pkg::coef_t coef_cascade_o
);

    // Input register, optional pre-adder reg, optional product reg, P register
    localparam int DEPTH = 2 + PREADD_REG + MULT_REG;

    logic               advance;
    fir_dsp_pkg::coef_t coef_work;
    fir_dsp_pkg::pre_t  pre_sum;
    fir_dsp_pkg::coef_t coef_s;
    fir_dsp_pkg::acc_t  c_s;
    fir_dsp_pkg::acc_t  pcin_s;

    ////////////////////
    // Handshake and stage enable
    ////////////////////

    fir_dsp_pipe_ctrl #(
        .DEPTH (DEPTH)
    ) u_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (in_valid_i),
        .out_ready_i (out_ready_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .advance_o   (advance)
    );

    // Coefficient loading runs independent of the data handshake
    fir_dsp_coef_bank u_coef (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .coef_load_i    (coef_load_i),
        .coef_update_i  (coef_update_i),
        .coef_i         (coef_i),
        .coef_work_o    (coef_work),
        .coef_cascade_o (coef_cascade_o)
    );

    ////////////////////
    // Datapath
    ////////////////////

    fir_dsp_preadd #(
        .USE_D      (USE_D),
        .SUBTRACT_A (SUBTRACT_A),
        .PREADD_REG (PREADD_REG)
    ) u_preadd (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .advance_i (advance),
        .a_i       (a_i),
        .d_i       (d_i),
        .coef_i    (coef_work),
        .c_i       (c_i),
        .pcin_i    (pcin_i),
        .pre_o     (pre_sum),
        .coef_o    (coef_s),
        .c_o       (c_s),
        .pcin_o    (pcin_s)
    );

    fir_dsp_mac #(
        .USE_C      (USE_C),
        .SUBTRACT_C (SUBTRACT_C),
        .ADD_PCIN   (ADD_PCIN),
        .RND_VAL    (RND_VAL),
        .MULT_REG   (MULT_REG)
    ) u_mac (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .advance_i (advance),
        .pre_i     (pre_sum),
        .coef_i    (coef_s),
        .c_i       (c_s),
        .pcin_i    (pcin_s),
        .p_o       (p_o)
    );

    // Cascade to the next slice is the same P word
    assign pcout_o = p_o;

endmodule

// ==== src/fir_dsp_mac.sv ====
`timescale 1ns/1ps

module fir_dsp_mac #(
    parameter bit                USE_C      = 1'b1,
    parameter bit                SUBTRACT_C = 1'b0,
    parameter bit                ADD_PCIN   = 1'b1,
    parameter fir_dsp_pkg::acc_t RND_VAL    = '0,
    parameter int                MULT_REG   = 0
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               advance_i,
    input  fir_dsp_pkg::pre_t  pre_i,
    input  fir_dsp_pkg::coef_t coef_i,
    input  fir_dsp_pkg::acc_t  c_i,
    input  fir_dsp_pkg::acc_t  pcin_i,
    output fir_dsp_pkg::acc_t  p_o
);

    localparam int PROD_W = fir_dsp_pkg::PROD_W;
    localparam int ACC_W  = fir_dsp_pkg::ACC_W;

    // Subtracting C is done as inverted C plus a carry in
    localparam bit C_NEG = USE_C && SUBTRACT_C;

    fir_dsp_pkg::prod_t prod;
    fir_dsp_pkg::prod_t prod_s;
    fir_dsp_pkg::acc_t  c_s;
    fir_dsp_pkg::acc_t  pcin_s;
    fir_dsp_pkg::acc_t  prod_ext;
    fir_dsp_pkg::acc_t  c_term;
    fir_dsp_pkg::acc_t  pcin_term;
    fir_dsp_pkg::acc_t  post_sum;
    fir_dsp_pkg::acc_t  p_q;

    ////////////////////
    // Multiplier
    ////////////////////

    // Both operands signed, so this is a signed 27x18 product
    assign prod = pre_i * coef_i;

    if (MULT_REG == 1) begin : g_mult_reg
        fir_dsp_pkg::prod_t prod_r;
        fir_dsp_pkg::acc_t  c_r;
        fir_dsp_pkg::acc_t  pcin_r;

        // C and PCIN ride along with the product
        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                prod_r <= '0;
                c_r    <= '0;
                pcin_r <= '0;
            end else if (advance_i) begin
                prod_r <= prod;
                c_r    <= c_i;
                pcin_r <= pcin_i;
            end
        end

        assign prod_s = prod_r;
        assign c_s    = c_r;
        assign pcin_s = pcin_r;
    end else begin : g_mult_comb
        assign prod_s = prod;
        assign c_s    = c_i;
        assign pcin_s = pcin_i;
    end

    ////////////////////
    // Post-adder
    ////////////////////

    assign prod_ext = {{(ACC_W-PROD_W){prod_s[PROD_W-1]}}, prod_s};

    assign c_term    = USE_C ? (C_NEG ? ~c_s : c_s) : '0;
    assign pcin_term = ADD_PCIN ? pcin_s : '0;

    // Wraps at 48 bits like the slice ALU
    assign post_sum = prod_ext + c_term + pcin_term + RND_VAL + C_NEG;

    // P register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            p_q <= '0;
        end else if (advance_i) begin
            p_q <= post_sum;
        end
    end

    assign p_o = p_q;

endmodule

// ==== src/fir_dsp_preadd.sv ====
`timescale 1ns/1ps

module fir_dsp_preadd #(
    parameter bit USE_D      = 1'b1,
    parameter bit SUBTRACT_A = 1'b0,
    parameter int PREADD_REG = 0
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               advance_i,
    input  fir_dsp_pkg::data_t a_i,
    input  fir_dsp_pkg::data_t d_i,
    input  fir_dsp_pkg::coef_t coef_i,
    input  fir_dsp_pkg::acc_t  c_i,
    input  fir_dsp_pkg::acc_t  pcin_i,
    output fir_dsp_pkg::pre_t  pre_o,
    output fir_dsp_pkg::coef_t coef_o,
    output fir_dsp_pkg::acc_t  c_o,
    output fir_dsp_pkg::acc_t  pcin_o
);

    fir_dsp_pkg::data_t a_q;
    fir_dsp_pkg::data_t d_q;
    fir_dsp_pkg::coef_t coef_q;
    fir_dsp_pkg::acc_t  c_q;
    fir_dsp_pkg::acc_t  pcin_q;
    fir_dsp_pkg::pre_t  a_term;
    fir_dsp_pkg::pre_t  d_term;
    fir_dsp_pkg::pre_t  pre_sum;

    ////////////////////
    // Input registers
    ////////////////////

    // The working coefficient is captured with the sample it belongs to
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            a_q    <= '0;
            d_q    <= '0;
            coef_q <= '0;
            c_q    <= '0;
            pcin_q <= '0;
        end else if (advance_i) begin
            a_q    <= a_i;
            d_q    <= d_i;
            coef_q <= coef_i;
            c_q    <= c_i;
            pcin_q <= pcin_i;
        end
    end

    // Sign extend by one bit before adding
    assign a_term = fir_dsp_pkg::pre_t'(a_q);
    assign d_term = USE_D ? fir_dsp_pkg::pre_t'(d_q) : '0;

    // D + A, D - A, +A or -A
    assign pre_sum = SUBTRACT_A ? (d_term - a_term) : (d_term + a_term);

    ////////////////////
    // Optional pre-adder register
    ////////////////////

    if (PREADD_REG == 1) begin : g_pre_reg
        fir_dsp_pkg::pre_t  pre_r;
        fir_dsp_pkg::coef_t coef_r;
        fir_dsp_pkg::acc_t  c_r;
        fir_dsp_pkg::acc_t  pcin_r;

        // Side operands get the same delay so the sample stays aligned
        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                pre_r  <= '0;
                coef_r <= '0;
                c_r    <= '0;
                pcin_r <= '0;
            end else if (advance_i) begin
                pre_r  <= pre_sum;
                coef_r <= coef_q;
                c_r    <= c_q;
                pcin_r <= pcin_q;
            end
        end

        assign pre_o  = pre_r;
        assign coef_o = coef_r;
        assign c_o    = c_r;
        assign pcin_o = pcin_r;
    end else begin : g_pre_comb
        assign pre_o  = pre_sum;
        assign coef_o = coef_q;
        assign c_o    = c_q;
        assign pcin_o = pcin_q;
    end

endmodule

// ==== src/fir_dsp_coef_bank.sv ====
`timescale 1ns/1ps

module fir_dsp_coef_bank (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               coef_load_i,
    input  logic               coef_update_i,
    input  fir_dsp_pkg::coef_t coef_i,
    output fir_dsp_pkg::coef_t coef_work_o,
    output fir_dsp_pkg::coef_t coef_cascade_o
);

    // First register is the shadow tap and second is the one the multiplier uses
    fir_dsp_pkg::coef_t coef_first;
    fir_dsp_pkg::coef_t coef_work;

    ////////////////////
    // Load stage
    ////////////////////

    // A chain of slices shifts new taps through the first registers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            coef_first <= '0;
        end else if (coef_load_i) begin
            coef_first <= coef_i;
        end
    end

    ////////////////////
    // Update stage
    ////////////////////

    // Old taps stay in use until update copies the shadow over
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            coef_work <= '0;
        end else if (coef_update_i) begin
            coef_work <= coef_first;
        end
    end

    assign coef_work_o    = coef_work;
    assign coef_cascade_o = coef_first;

endmodule

// ==== src/fir_dsp_pipe_ctrl.sv ====
`timescale 1ns/1ps

module fir_dsp_pipe_ctrl #(
    parameter int DEPTH = 2
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic in_valid_i,
    input  logic out_ready_i,
    output logic in_ready_o,
    output logic out_valid_o,
    output logic advance_o
);

    // One valid flag per register stage with index 0 at the input register
    logic [DEPTH-1:0] stage_vld;
    logic             advance;

    ////////////////////
    // Shared stage enable
    ////////////////////

    // The pipeline moves unless the last stage holds a result nobody takes.
    // Bubbles in earlier stages get overwritten, so no per-stage stall
    assign advance = ~stage_vld[DEPTH-1] | out_ready_i;

    assign advance_o   = advance;
    assign in_ready_o  = advance;
    assign out_valid_o = stage_vld[DEPTH-1];

    ////////////////////
    // Valid shift register
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stage_vld <= '0;
        end else if (advance) begin
            // New sample enters stage 0, everything else moves one step
            stage_vld <= {stage_vld[DEPTH-2:0], in_valid_i};
        end
    end

endmodule

// ==== src/fir_dsp_pkg.sv ====
package fir_dsp_pkg;

    ////////////////////
    // Operand and result widths
    ////////////////////

    // A and D data samples
    localparam int DATA_W = 26;

    // Coefficient (B port on the slice)
    localparam int COEF_W = 18;

    // Pre-adder keeps one extra bit so D +/- A never overflows
    localparam int PRE_W = DATA_W + 1;

    // Full product width
    localparam int PROD_W = PRE_W + COEF_W;

    // C, PCIN, P and PCOUT
    localparam int ACC_W = 48;

    ////////////////////
    // Vector types
    ////////////////////

    typedef logic signed [DATA_W-1:0] data_t;

    typedef logic signed [COEF_W-1:0] coef_t;

    typedef logic signed [PRE_W-1:0] pre_t;

    typedef logic signed [PROD_W-1:0] prod_t;

    // Accumulator word that wraps modulo 2**48
    typedef logic [ACC_W-1:0] acc_t;

endpackage
